// ==== rtl/pkt_word_pkg.sv ====
/*
 * Packet word format shared by the classifier datapath.
 * Defines the 8-byte word, its byte length and word offset,
 * and the structs carried on the ingress and egress sides.
 */

`default_nettype none

package pkt_word_pkg;

  // Eight bytes, byte i at bits 8i+7:8i
  typedef logic [63:0] word_data_t;

  // Index of the last valid byte on an EOP word
  typedef logic [2:0] byte_len_t;

  // Word index within a packet, SOP word is 0
  typedef logic [7:0] word_off_t;

  // Buffer tag width travels with the egress word
  typedef logic [15:0] buf_tag_t;

  // Word as presented at the input
  typedef struct packed {
    logic       sop;
    logic       eop;
    byte_len_t  length;
    word_data_t data;
  } in_word_t;

  // Forwarded word plus the classification result
  typedef struct packed {
    logic       sop;
    logic       eop;
    byte_len_t  length;
    word_data_t data;
    buf_tag_t   buffer;
  } out_word_t;

endpackage

`default_nettype wire

// ==== rtl/match_cfg_pkg.sv ====
/*
 * Match configuration types for the packet classifier.
 * Holds the packet type and its location, the symbol table
 * entries and the helper that expands an EOP length to a byte mask.
 */

`default_nettype none

package match_cfg_pkg;

  localparam int NUM_SYMBOLS       = 4;
  localparam int TYPE_BYTES        = 4;
  // Last start byte where the whole type fits in one word
  localparam int MAX_TYPE_BYTE_OFF = 4;

  // Type byte j expected at data byte offset+j
  typedef logic [8*TYPE_BYTES-1:0] pkt_type_t;
  typedef logic [2:0]              byte_off_t;
  typedef pkt_word_pkg::buf_tag_t  buffer_t;

  typedef struct packed {
    pkt_word_pkg::word_off_t word_off;
    byte_off_t               byte_off;
  } type_loc_t;

  typedef struct packed {
    logic                    valid;
    pkt_word_pkg::word_off_t word_off;
    logic [63:0]             value;
    buffer_t                 buffer;
  } sym_entry_t;

  typedef struct packed {
    pkt_type_t                    pkt_type;
    type_loc_t                    type_loc;
    sym_entry_t [NUM_SYMBOLS-1:0] symbols;
  } match_cfg_t;

  // Bytes 0 up to len are valid
  function automatic logic [7:0] len_to_byte_mask(pkt_word_pkg::byte_len_t len);
    logic [7:0] mask;
    for (int i = 0; i < 8; i++) begin
      mask[i] = (i <= int'(len));
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/pkt_ingress.sv ====
/*
 * Input stage of the classifier.
 * Registers each incoming word and latches the match configuration
 * on SOP, so the next packet's operands are ready for its first word.
 */

`default_nettype none
`timescale 1ns/1ps

module pkt_ingress (
    input  logic                      clk_net
  , input  logic                      rst_net
  , input  logic                      in_vld
  , input  pkt_word_pkg::in_word_t    in_word
  , input  match_cfg_pkg::match_cfg_t cfg
  , output logic                      word_vld
  , output pkt_word_pkg::in_word_t    word
  , output match_cfg_pkg::match_cfg_t cfg_q
  , output logic                      pkt_start
);

  // SOP at the input, one cycle ahead of the registered word
  assign pkt_start = in_vld & in_word.sop;

  // Registered word valid
  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      word_vld <= 1'b0;
    end else begin
      word_vld <= in_vld;
    end
  end

  // Payload only captured on valid cycles
  always_ff @(posedge clk_net) begin
    if (in_vld) begin
      word <= in_word;
    end
  end

  // Operands held for the whole packet
  always_ff @(posedge clk_net) begin
    if (pkt_start) begin
      cfg_q <= cfg;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/word_tracker.sv ====
/*
 * Packet framing FSM.
 * Tracks whether a packet is open, accepts words belonging to a
 * packet, drops stray words seen while idle and counts word offsets.
 */

`default_nettype none
`timescale 1ns/1ps

module word_tracker (
    input  logic                    clk_net
  , input  logic                    rst_net
  , input  logic                    word_vld
  , input  pkt_word_pkg::in_word_t  word
  , input  logic                    pkt_start
  , output logic                    can_match
  , output logic                    eop_emit
  , output logic                    emit
  , output pkt_word_pkg::word_off_t word_off
);

  typedef enum logic [0:0] {
    IDLE      = 1'b0,
    IN_PACKET = 1'b1
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   accept;

  // A new SOP opens a packet even mid-packet
  assign accept = word_vld & ((state_q == IN_PACKET) | word.sop);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Stray body words are ignored here
        if (accept && !word.eop) begin
          state_d = IN_PACKET;
        end
      end
      IN_PACKET: begin
        if (accept && word.eop) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Offset zeroed as the SOP enters, so it reads 0 on the SOP word
  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      word_off <= '0;
    end else if (pkt_start) begin
      word_off <= '0;
    end else if (accept) begin
      word_off <= word_off + 8'd1;
    end
  end

  // Every accepted word carries payload worth matching
  assign can_match = accept;
  assign emit      = accept;
  assign eop_emit  = accept & word.eop;

  // The SOP word always starts at offset zero
  a_sop_offset_zero : assert property (@(posedge clk_net) disable iff (rst_net)
    (emit && word.sop) |-> (word_off == '0));

endmodule

`default_nettype wire

// ==== rtl/type_matcher.sv ====
/*
 * Packet type detector.
 * In the configured word, compares the type against each start
 * byte where it fits entirely, honouring the EOP byte length.
 */

`default_nettype none
`timescale 1ns/1ps

module type_matcher (
    input  logic                      word_vld
  , input  pkt_word_pkg::in_word_t    word
  , input  pkt_word_pkg::word_off_t   word_off
  , input  match_cfg_pkg::match_cfg_t cfg_q
  , output logic                      type_found
);

  import match_cfg_pkg::*;

  logic [7:0]                 valid_mask;
  logic                       in_type_word;
  logic                       off_in_range;
  logic [MAX_TYPE_BYTE_OFF:0] pos_hit;

  always_comb begin
    // Length only matters on the tail word
    valid_mask   = word.eop ? len_to_byte_mask(word.length) : 8'hff;
    in_type_word = (word_off == cfg_q.type_loc.word_off);
    // Type may not straddle words
    off_in_range = (cfg_q.type_loc.byte_off <= byte_off_t'(MAX_TYPE_BYTE_OFF));

    // One comparator per legal alignment
    for (int i = 0; i <= MAX_TYPE_BYTE_OFF; i++) begin
      pos_hit[i] = 1'b1;
      for (int j = 0; j < TYPE_BYTES; j++) begin
        pos_hit[i] &= valid_mask[i+j] &
                      (word.data[8*(i+j) +: 8] == cfg_q.pkt_type[8*j +: 8]);
      end
    end
  end

  // Select the configured alignment
  assign type_found = word_vld & in_type_word & off_in_range &
                      pos_hit[cfg_q.type_loc.byte_off];

endmodule

`default_nettype wire

// ==== rtl/symbol_matcher.sv ====
/*
 * Symbol table lookup.
 * Compares a full 8-byte word against every valid entry placed at
 * the current word offset; the highest matching index supplies the tag.
 */

`default_nettype none
`timescale 1ns/1ps

module symbol_matcher (
    input  logic                      word_vld
  , input  pkt_word_pkg::in_word_t    word
  , input  pkt_word_pkg::word_off_t   word_off
  , input  match_cfg_pkg::match_cfg_t cfg_q
  , output logic                      sym_found
  , output match_cfg_pkg::buffer_t    sym_buffer
);

  import match_cfg_pkg::*;

  logic full_word;
  logic any_hit;

  always_comb begin
    // Symbol needs all eight bytes
    full_word  = ~word.eop | (word.length == 3'd7);
    any_hit    = 1'b0;
    sym_buffer = '0;

    // Ascending scan, later hits overwrite earlier ones
    for (int i = 0; i < NUM_SYMBOLS; i++) begin
      if (cfg_q.symbols[i].valid &&
          (cfg_q.symbols[i].word_off == word_off) &&
          (cfg_q.symbols[i].value == word.data)) begin
        any_hit    = 1'b1;
        sym_buffer = cfg_q.symbols[i].buffer;
      end
    end
  end

  // Explicit flag since a zero tag is a legal entry value
  assign sym_found = word_vld & full_word & any_hit;

endmodule

`default_nettype wire

// ==== rtl/match_accumulator.sv ====
/*
 * Per-packet match state.
 * Collects type and symbol hits across the packet and builds the
 * egress word, attaching the buffer tag on EOP when both were seen.
 */

`default_nettype none
`timescale 1ns/1ps

module match_accumulator (
    input  logic                    clk_net
  , input  logic                    rst_net
  , input  logic                    pkt_start
  , input  logic                    can_match
  , input  logic                    emit
  , input  logic                    eop_emit
  , input  pkt_word_pkg::in_word_t  word
  , input  logic                    type_found
  , input  logic                    sym_found
  , input  match_cfg_pkg::buffer_t  sym_buffer
  , output logic                    push
  , output pkt_word_pkg::out_word_t push_word
);

  import match_cfg_pkg::*;

  typedef struct packed {
    logic    got_type;
    logic    got_symbol;
    buffer_t buffer;
  } match_state_t;

  match_state_t state_q;
  match_state_t state_now;

  // Retained state merged with this word's findings
  always_comb begin
    state_now = state_q;
    if (can_match && type_found) begin
      state_now.got_type = 1'b1;
    end
    // Most recent symbol hit wins
    if (can_match && sym_found) begin
      state_now.got_symbol = 1'b1;
      state_now.buffer     = sym_buffer;
    end
  end

  // Cleared as the next SOP enters the input register
  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      state_q <= '0;
    end else if (pkt_start) begin
      state_q <= '0;
    end else if (can_match) begin
      state_q <= state_now;
    end
  end

  always_comb begin
    push_word.sop    = word.sop;
    push_word.eop    = word.eop;
    push_word.length = word.length;
    push_word.data   = word.data;
    // Tag only on the tail word and only with both hits
    push_word.buffer = '0;
    if (eop_emit && state_now.got_type && state_now.got_symbol) begin
      push_word.buffer = state_now.buffer;
    end
  end

  assign push = emit;

endmodule

`default_nettype wire

// ==== rtl/egress_queue.sv ====
/*
 * Output queue of the classifier.
 * Circular buffer of egress words; the head is offered over a
 * four-phase req/ack handshake. Pushes into a full queue are
 * dropped and raise a sticky overflow flag.
 */

`default_nettype none
`timescale 1ns/1ps

module egress_queue #(
  parameter int unsigned QUEUE_DEPTH = 16
) (
    input  logic                    clk_net
  , input  logic                    rst_net
  , input  logic                    push
  , input  pkt_word_pkg::out_word_t push_word
  , input  logic                    out_ack
  , output logic                    out_req
  , output pkt_word_pkg::out_word_t out_word
  , output logic                    overflow
);

  import pkt_word_pkg::*;

  localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);

  // Extra MSB tells full from empty
  typedef logic [PTR_W:0] q_ptr_t;

  out_word_t mem [QUEUE_DEPTH];
  q_ptr_t    wr_ptr;
  q_ptr_t    rd_ptr;
  logic      empty;
  logic      full;
  logic      wr_en;
  logic      pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign wr_en = push & ~full;
  // Ack seen while requesting completes phase 3
  assign pop   = out_req & out_ack;

  always_ff @(posedge clk_net) begin
    if (wr_en) begin
      mem[wr_ptr[PTR_W-1:0]] <= push_word;
    end
  end

  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Request rises only once ack from the last word is gone
  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      out_req <= 1'b0;
    end else if (pop) begin
      out_req <= 1'b0;
    end else if (!out_req && !out_ack && !empty) begin
      out_req <= 1'b1;
    end
  end

  // Sticky until reset
  always_ff @(posedge clk_net) begin
    if (rst_net) begin
      overflow <= 1'b0;
    end else if (push && full) begin
      overflow <= 1'b1;
    end
  end

  // Head of queue
  assign out_word = mem[rd_ptr[PTR_W-1:0]];

  a_word_stable : assert property (@(posedge clk_net) disable iff (rst_net)
    (out_req && !out_ack) |=> $stable(out_word));

  // Ack may only answer a pending request
  a_ack_after_req : assert property (@(posedge clk_net) disable iff (rst_net)
    $rose(out_ack) |-> out_req);

endmodule

`default_nettype wire

// ==== rtl/pkt_classifier.sv ====
/*
 * Packet classifier top level.
 * Connects the ingress register, framing and match logic and the
 * egress queue; QUEUE_DEPTH sets the number of words in flight.
 */

`default_nettype none
`timescale 1ns/1ps

module pkt_classifier #(
  parameter int unsigned QUEUE_DEPTH = 16
) (
    input  logic                      clk_net
  , input  logic                      rst_net
  , input  logic                      in_vld
  , input  pkt_word_pkg::in_word_t    in_word
  , input  match_cfg_pkg::match_cfg_t cfg
  , output logic                      out_req
  , output pkt_word_pkg::out_word_t   out_word
  , input  logic                      out_ack
  , output logic                      overflow
);

  import pkt_word_pkg::*;
  import match_cfg_pkg::*;

  // Registered input stage
  logic       word_vld;
  in_word_t   word;
  match_cfg_t cfg_q;
  logic       pkt_start;

  // Framing
  logic       can_match;
  logic       eop_emit;
  logic       emit;
  word_off_t  word_off;

  // Match results
  logic       type_found;
  logic       sym_found;
  buffer_t    sym_buffer;

  // Into the queue
  logic       push;
  out_word_t  push_word;

  pkt_ingress u_ingress (
    .clk_net, .rst_net, .in_vld, .in_word, .cfg,
    .word_vld, .word, .cfg_q, .pkt_start
  );

  word_tracker u_tracker (
    .clk_net, .rst_net, .word_vld, .word, .pkt_start,
    .can_match, .eop_emit, .emit, .word_off
  );

  type_matcher u_type (
    .word_vld, .word, .word_off, .cfg_q, .type_found
  );

  symbol_matcher u_symbol (
    .word_vld, .word, .word_off, .cfg_q, .sym_found, .sym_buffer
  );

  match_accumulator u_accum (
    .clk_net, .rst_net, .pkt_start, .can_match, .emit, .eop_emit, .word,
    .type_found, .sym_found, .sym_buffer, .push, .push_word
  );

  egress_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clk_net, .rst_net, .push, .push_word, .out_ack,
    .out_req, .out_word, .overflow
  );

endmodule

`default_nettype wire

// ==== tb/classifier_model.svh ====
/*
 * Reference model of the classifier result for one packet.
 * Included in the testbench body, after the package imports.
 */

`ifndef CLASSIFIER_MODEL_SVH
`define CLASSIFIER_MODEL_SVH

// Buffer tag expected on the EOP word of a packet of n_words words
function automatic buffer_t expected_tag(input in_word_t words [MAX_WORDS],
                                         input int n_words, input match_cfg_t c);
  logic    seen_type;
  logic    seen_sym;
  logic    hit;
  buffer_t tag;
  int      last_byte;
  seen_type = 1'b0;
  seen_sym  = 1'b0;
  tag       = '0;
  for (int w = 0; w < n_words; w++) begin
    // Highest byte index present in this word
    last_byte = words[w].eop ? int'(words[w].length) : 7;
    // Type must sit wholly inside the valid bytes of its word
    if (w == int'(c.type_loc.word_off) && int'(c.type_loc.byte_off) + 3 <= last_byte) begin
      hit = 1'b1;
      for (int j = 0; j < TYPE_BYTES; j++) begin
        if (words[w].data[8*(int'(c.type_loc.byte_off)+j) +: 8] != c.pkt_type[8*j +: 8]) begin
          hit = 1'b0;
        end
      end
      if (hit) begin
        seen_type = 1'b1;
      end
    end
    // Symbols only in complete words, highest entry wins
    if (last_byte == 7) begin
      for (int i = 0; i < NUM_SYMBOLS; i++) begin
        if (c.symbols[i].valid && int'(c.symbols[i].word_off) == w &&
            c.symbols[i].value == words[w].data) begin
          seen_sym = 1'b1;
          tag      = c.symbols[i].buffer;
        end
      end
    end
  end
  return (seen_type && seen_sym) ? tag : buffer_t'(0);
endfunction

`endif

// ==== tb/tb_pkt_classifier.sv ====
/*
 * Testbench for the packet classifier.
 * Drives random and directed packets, answers the four-phase output
 * handshake and checks every forwarded word against the reference model.
 */

`default_nettype none
`timescale 1ns/1ps

module tb_pkt_classifier;

  import pkt_word_pkg::*;
  import match_cfg_pkg::*;

  localparam int          QUEUE_DEPTH = 16;
  localparam int          MAX_WORDS   = 24;
  localparam int          DRAIN_LIMIT = 2000;
  localparam pkt_type_t   TYPE_VAL    = 32'ha1b2c3d4;
  localparam logic [63:0] SYM_VAL     = 64'h0123_4567_89ab_cdef;
  localparam logic [63:0] SYM_ALT     = 64'hfedc_ba98_7654_3210;

  logic       clk_net;
  logic       rst_net;
  logic       in_vld;
  in_word_t   in_word;
  match_cfg_t cfg;
  logic       out_req;
  out_word_t  out_word;
  logic       out_ack;
  logic       overflow;

  integer     seed;
  logic       stall_ack;
  out_word_t  exp_q [$];
  in_word_t   pkt [MAX_WORDS];
  match_cfg_t c;
  in_word_t   stray;
  int         err_count;
  int         check_count;
  int         test_count;
  int         test_fail_count;
  int         errs_before;
  int         cycles;
  int         n_words;

  `include "classifier_model.svh"

  pkt_classifier #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut0 (
    .clk_net, .rst_net, .in_vld, .in_word, .cfg,
    .out_req, .out_word, .out_ack, .overflow
  );

  initial begin
    clk_net = 1'b0;
    forever #10 clk_net = ~clk_net;
  end

  // Responder raises ack after req and drops it once req falls
  initial begin
    out_ack = 1'b0;
    forever begin
      @(posedge clk_net);
      #2;
      if (out_req && !out_ack && !stall_ack) begin
        out_ack = 1'b1;
      end else if (!out_req && out_ack) begin
        out_ack = 1'b0;
      end
    end
  end

  task automatic check_field(input string name, input logic [63:0] expv,
                             input logic [63:0] gotv);
    check_count++;
    if (expv !== gotv) begin
      err_count++;
      $display("Mismatch %s: expected %h, got %h", name, expv, gotv);
    end
  endtask

  // Req and ack are both high for exactly one cycle per word
  initial begin
    out_word_t exp;
    forever begin
      @(negedge clk_net);
      if (out_req && out_ack) begin
        if (exp_q.size() == 0) begin
          err_count++;
          $display("Output word %h appeared while no word was expected", out_word);
        end else begin
          exp = exp_q.pop_front();
          check_field("out_word.sop", exp.sop, out_word.sop);
          check_field("out_word.eop", exp.eop, out_word.eop);
          check_field("out_word.length", exp.length, out_word.length);
          check_field("out_word.data", exp.data, out_word.data);
          check_field("out_word.buffer", exp.buffer, out_word.buffer);
        end
      end
    end
  end

  // Inputs change shortly after the rising edge
  task automatic drive_word(input logic vld, input in_word_t w, input match_cfg_t cw);
    @(posedge clk_net);
    #2;
    in_vld  = vld;
    in_word = w;
    cfg     = cw;
  endtask

  task automatic make_packet(input int n);
    for (int i = 0; i < n; i++) begin
      pkt[i].sop    = (i == 0);
      pkt[i].eop    = (i == n - 1);
      pkt[i].length = 3'($random(seed));
      pkt[i].data   = {32'($random(seed)), 32'($random(seed))};
    end
  endtask

  task automatic make_cfg(output match_cfg_t cr);
    cr.pkt_type          = 32'($random(seed));
    cr.type_loc.word_off = 8'($unsigned($random(seed)) % 8);
    cr.type_loc.byte_off = 3'($random(seed));
    for (int i = 0; i < NUM_SYMBOLS; i++) begin
      cr.symbols[i].valid    = 1'($random(seed));
      cr.symbols[i].word_off = 8'($unsigned($random(seed)) % 8);
      cr.symbols[i].value    = {32'($random(seed)), 32'($random(seed))};
      cr.symbols[i].buffer   = 16'($random(seed));
    end
  endtask

  // Type at a given location, all symbol entries invalid
  task automatic base_cfg(output match_cfg_t cr, input int type_word, input int type_byte);
    cr                   = '0;
    cr.pkt_type          = TYPE_VAL;
    cr.type_loc.word_off = word_off_t'(type_word);
    cr.type_loc.byte_off = byte_off_t'(type_byte);
  endtask

  task automatic set_sym(inout match_cfg_t cr, input int idx, input int w,
                         input logic [63:0] v, input buffer_t b);
    cr.symbols[idx].valid    = 1'b1;
    cr.symbols[idx].word_off = word_off_t'(w);
    cr.symbols[idx].value    = v;
    cr.symbols[idx].buffer   = b;
  endtask

  // Bytes past the word end are simply not written
  task automatic put_type(input int w, input int b);
    for (int j = 0; j < TYPE_BYTES; j++) begin
      if (b + j < 8) begin
        pkt[w].data[8*(b+j) +: 8] = TYPE_VAL[8*j +: 8];
      end
    end
  endtask

  // Waits until every expected word has left and the handshake is idle
  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || out_req || out_ack) && n < DRAIN_LIMIT) begin
      @(posedge clk_net);
      n++;
    end
    if (exp_q.size() != 0 || out_req || out_ack) begin
      err_count++;
      $display("Timeout: handshake not idle with %0d expected words still pending",
               exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic send_packet(input int n, input match_cfg_t cp, input logic drain);
    buffer_t tag;
    tag = expected_tag(pkt, n, cp);
    for (int i = 0; i < n; i++) begin
      exp_q.push_back({pkt[i], (i == n - 1) ? tag : buffer_t'(0)});
    end
    for (int i = 0; i < n; i++) begin
      drive_word(1'b1, pkt[i], cp);
    end
    drive_word(1'b0, '0, cp);
    if (drain) begin
      wait_drain();
    end
  endtask

  task automatic end_test(input string name, input int errs0, input logic ovf_exp);
    check_field("overflow", ovf_exp, overflow);
    test_count++;
    if (err_count != errs0) begin
      test_fail_count++;
      $display("%s: failed with %0d errors", name, err_count - errs0);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  initial begin
    seed            = 95671;
    rst_net         = 1'b1;
    in_vld          = 1'b0;
    in_word         = '0;
    cfg             = '0;
    stall_ack       = 1'b0;
    err_count       = 0;
    check_count     = 0;
    test_count      = 0;
    test_fail_count = 0;
    repeat (16) @(posedge clk_net);
    #2;
    rst_net = 1'b0;

    // Random traffic forwarded unchanged
    errs_before = err_count;
    check_field("out_req", 1'b0, out_req);
    check_field("overflow", 1'b0, overflow);
    for (int p = 0; p < 6; p++) begin
      make_cfg(c);
      n_words = 1 + int'($unsigned($random(seed)) % 8);
      make_packet(n_words);
      send_packet(n_words, c, 1'b1);
    end
    end_test("random forwarding", errs_before, 1'b0);

    // Type and symbol present, every legal alignment
    errs_before = err_count;
    for (int b = 0; b <= MAX_TYPE_BYTE_OFF; b++) begin
      base_cfg(c, 1, b);
      set_sym(c, 1, 3, SYM_VAL, 16'h1234 + 16'(b));
      make_packet(5);
      put_type(1, b);
      pkt[3].data = SYM_VAL;
      send_packet(5, c, 1'b1);
    end
    end_test("tag on full match", errs_before, 1'b0);

    // Single finding gives no tag, strays before SOP are dropped
    errs_before = err_count;
    base_cfg(c, 1, 2);
    set_sym(c, 0, 2, SYM_VAL, 16'h5a5a);
    make_packet(4);
    put_type(1, 2);
    send_packet(4, c, 1'b1);
    make_packet(4);
    pkt[2].data = SYM_VAL;
    send_packet(4, c, 1'b1);
    for (int s = 0; s < 3; s++) begin
      stray.sop    = 1'b0;
      stray.eop    = (s == 2);
      stray.length = 3'd7;
      stray.data   = {32'($random(seed)), 32'($random(seed))};
      drive_word(1'b1, stray, c);
    end
    make_packet(4);
    put_type(1, 2);
    pkt[2].data = SYM_VAL;
    send_packet(4, c, 1'b1);
    end_test("partial match and strays", errs_before, 1'b0);

    // Type past the last alignment
    errs_before = err_count;
    base_cfg(c, 1, 5);
    set_sym(c, 2, 2, SYM_VAL, 16'h0bad);
    make_packet(4);
    put_type(1, 5);
    pkt[2].data = SYM_VAL;
    send_packet(4, c, 1'b1);
    // Type in the EOP word cut off at length 5 and just fitting at 6
    for (int len = 5; len <= 6; len++) begin
      base_cfg(c, 3, 3);
      set_sym(c, 0, 1, SYM_VAL, 16'h7e57);
      make_packet(4);
      pkt[1].data   = SYM_VAL;
      put_type(3, 3);
      pkt[3].length = byte_len_t'(len);
      send_packet(4, c, 1'b1);
    end
    // Symbol in a short and in a full EOP word
    for (int len = 6; len <= 7; len++) begin
      base_cfg(c, 1, 0);
      set_sym(c, 3, 4, SYM_VAL, 16'h4e0f);
      make_packet(5);
      put_type(1, 0);
      pkt[4].data   = SYM_VAL;
      pkt[4].length = byte_len_t'(len);
      send_packet(5, c, 1'b1);
    end
    end_test("alignment and length limits", errs_before, 1'b0);

    // Two valid hits on one word plus an invalid entry that must be ignored
    errs_before = err_count;
    base_cfg(c, 1, 4);
    set_sym(c, 0, 2, SYM_VAL, 16'h00a0);
    set_sym(c, 2, 2, SYM_VAL, 16'h00c2);
    set_sym(c, 3, 2, SYM_VAL, 16'h00e3);
    c.symbols[3].valid = 1'b0;
    make_packet(3);
    put_type(1, 4);
    pkt[2].data = SYM_VAL;
    send_packet(3, c, 1'b1);
    c.symbols[0].value = SYM_ALT;
    c.symbols[2].value = SYM_ALT;
    send_packet(3, c, 1'b1);
    end_test("entry priority", errs_before, 1'b0);

    // More words than the queue holds while the responder stalls
    errs_before = err_count;
    stall_ack   = 1'b1;
    make_cfg(c);
    for (int p = 0; p < 3; p++) begin
      make_packet(8 - p);
      send_packet(8 - p, c, 1'b0);
    end
    // Only the oldest words fit, the rest are dropped
    while (exp_q.size() > QUEUE_DEPTH) begin
      void'(exp_q.pop_back());
    end
    cycles = 0;
    while (!overflow && cycles < 100) begin
      @(posedge clk_net);
      cycles++;
    end
    if (!overflow) begin
      err_count++;
      $display("Overflow flag did not rise after the queue was overfilled");
    end
    check_field("out_req", 1'b1, out_req);
    stall_ack = 1'b0;
    wait_drain();
    end_test("queue overflow", errs_before, 1'b1);

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             test_count, test_fail_count, check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tb
rtl/pkt_word_pkg.sv
rtl/match_cfg_pkg.sv
rtl/pkt_ingress.sv
rtl/word_tracker.sv
rtl/type_matcher.sv
rtl/symbol_matcher.sv
rtl/match_accumulator.sv
rtl/egress_queue.sv
rtl/pkt_classifier.sv
tb/tb_pkt_classifier.sv

// ==== Bender.yml ====
package:
  name: pkt_classifier

sources:
  - rtl/pkt_word_pkg.sv
  - rtl/match_cfg_pkg.sv
  - rtl/pkt_ingress.sv
  - rtl/word_tracker.sv
  - rtl/type_matcher.sv
  - rtl/symbol_matcher.sv
  - rtl/match_accumulator.sv
  - rtl/egress_queue.sv
  - rtl/pkt_classifier.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_pkt_classifier.sv
